//--- hdl/spiPkg.sv
package spiPkg;

  //////////////////////////////
  // FIFO sizing
  //////////////////////////////

  // Both FIFOs hold 2**fifoDepthLog entries
  localparam int fifoDepthLog = 3;
  localparam int fifoDepth = 1 << fifoDepthLog;

  // Register offsets, word aligned
  typedef enum logic [7:0] {
    SCKDIV  = 8'h00,
    SCKMODE = 8'h04,
    CSID    = 8'h10,
    CSDEF   = 8'h14,
    CSMODE  = 8'h18,
    FMT     = 8'h40,
    TXDATA  = 8'h48,
    RXDATA  = 8'h4C,
    TXMARK  = 8'h50,
    RXMARK  = 8'h54,
    IE      = 8'h70,
    IP      = 8'h74
  } regAddr;

  // Configuration seen by the datapath
  typedef struct packed {
    logic [11:0] sckDiv;
    logic        sckPol;
    logic        sckPha;
    logic [1:0]  csId;
    logic [3:0]  csDef;
    logic        csOff;
    logic [3:0]  frameLen;
    logic        lsbFirst;
  } spiCfg;

  // Single-cycle strobes from the controller
  typedef struct packed {
    logic sckTick;
    logic shiftEdge;
    logic sampleEdge;
    logic endOfFrame;
  } spiTicks;

  typedef enum logic [1:0] {IDLE, ACTIVE, GAP} frameState;
  typedef enum logic [1:0] {READY, START, WAIT} startState;

  // Values after reset: div 3, mode 0, CS 0 with all high, 8-bit MSB-first
  localparam spiCfg cfgReset = '{
    sckDiv: 12'd3, sckPol: 1'b0, sckPha: 1'b0, csId: 2'd0,
    csDef: 4'b1111, csOff: 1'b0, frameLen: 4'd8, lsbFirst: 1'b0
  };

endpackage

//--- hdl/spiFifo.sv
`timescale 1ns/10ps

module spiFifo import spiPkg::*; (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  logic                    push,
  input  logic                    pop,
  input  logic [7:0]              wrData,
  input  logic [fifoDepthLog-1:0] mark,
  output logic [7:0]              rdData,
  output logic                    full,
  output logic                    empty,
  output logic                    belowMark,
  output logic                    aboveMark
);

  logic [7:0]              mem [fifoDepth];
  logic [fifoDepthLog-1:0] wrPtr;
  logic [fifoDepthLog-1:0] rdPtr;
  // One extra bit so a full FIFO is distinct from an empty one
  logic [fifoDepthLog:0]   count;
  logic                    doPush;
  logic                    doPop;

  // Writes to a full FIFO and reads from an empty one are ignored
  assign doPush = push & ~full;
  assign doPop  = pop & ~empty;

  // Storage
  always_ff @(posedge PCLK) begin
    if (doPush) begin
      mem[wrPtr] <= wrData;
    end
  end

  // Pointers wrap on their own at the power-of-two depth
  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop) rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head is visible without a read strobe
  assign rdData = mem[rdPtr];
  assign full   = (count == (fifoDepthLog+1)'(fifoDepth));
  assign empty  = (count == '0);

  // Watermark compares, strict in both directions
  assign belowMark = (count < {1'b0, mark});
  assign aboveMark = (count > {1'b0, mark});

endmodule

//--- hdl/spiRegs.sv
`timescale 1ns/10ps

module spiRegs import spiPkg::*; (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  logic                    PSEL,
  input  logic                    PENABLE,
  input  logic                    PWRITE,
  input  logic [7:0]              PADDR,
  input  logic [31:0]             PWDATA,
  output logic [31:0]             PRDATA,
  output spiCfg                   cfg,
  output logic                    txPush,
  output logic [7:0]              txWrData,
  output logic                    rxPop,
  output logic [fifoDepthLog-1:0] txMark,
  output logic [fifoDepthLog-1:0] rxMark,
  input  logic                    txFull,
  input  logic                    rxEmpty,
  input  logic [7:0]              rxRdData,
  input  logic                    txBelowMark,
  input  logic                    rxAboveMark,
  output logic                    sckRestart,
  output logic                    SPIIntr
);

  regAddr     addr;
  logic       wrEn;
  logic       rdEn;
  // Bit 0 transmit watermark, bit 1 receive watermark
  logic [1:0] ie;
  logic [1:0] ip;

  // Offsets are word aligned so the low address bits drop out
  assign addr = regAddr'({PADDR[7:2], 2'b00});
  // Access phase only
  assign wrEn = PSEL & PENABLE & PWRITE;
  assign rdEn = PSEL & PENABLE & ~PWRITE;

  // FIFO strobes land on the edge that closes the access phase
  assign txPush     = wrEn & (addr == TXDATA) & ~txFull;
  assign txWrData   = PWDATA[7:0];
  // Pop only when the captured read returned a byte
  assign rxPop      = rdEn & (addr == RXDATA) & ~PRDATA[31];
  // Divider starts a fresh half period after a new SCKDIV
  assign sckRestart = wrEn & (addr == SCKDIV);

  //////////////////////////////
  // Register writes
  //////////////////////////////
  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      cfg    <= cfgReset;
      txMark <= '0;
      rxMark <= '0;
      ie     <= '0;
      ip     <= '0;
    end else begin
      if (wrEn) begin
        case (addr)
          SCKDIV: cfg.sckDiv <= PWDATA[11:0];
          SCKMODE: begin
            cfg.sckPha <= PWDATA[0];
            cfg.sckPol <= PWDATA[1];
          end
          CSID:   cfg.csId <= PWDATA[1:0];
          CSDEF:  cfg.csDef <= PWDATA[3:0];
          // Only auto (0) and off (3) exist
          CSMODE: cfg.csOff <= &PWDATA[1:0];
          FMT: begin
            cfg.frameLen <= PWDATA[19:16];
            cfg.lsbFirst <= PWDATA[2];
          end
          TXMARK: txMark <= PWDATA[fifoDepthLog-1:0];
          RXMARK: rxMark <= PWDATA[fifoDepthLog-1:0];
          IE:     ie <= PWDATA[1:0];
          default: ;
        endcase
      end
      // Pending bits trail the FIFO levels by one cycle
      ip <= {rxAboveMark, txBelowMark};
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////
  // Captured at the end of setup so it holds through access
  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      PRDATA <= '0;
    end else if (PSEL && !PENABLE) begin
      case (addr)
        SCKDIV:  PRDATA <= {20'b0, cfg.sckDiv};
        SCKMODE: PRDATA <= {30'b0, cfg.sckPol, cfg.sckPha};
        CSID:    PRDATA <= {30'b0, cfg.csId};
        CSDEF:   PRDATA <= {28'b0, cfg.csDef};
        CSMODE:  PRDATA <= {30'b0, cfg.csOff, cfg.csOff};
        FMT:     PRDATA <= {12'b0, cfg.frameLen, 13'b0, cfg.lsbFirst, 2'b0};
        // Bit 31 flags a full transmit FIFO
        TXDATA:  PRDATA <= {txFull, 31'b0};
        // Bit 31 flags an empty receive FIFO
        RXDATA:  PRDATA <= {rxEmpty, 23'b0, rxRdData};
        TXMARK:  PRDATA <= 32'(txMark);
        RXMARK:  PRDATA <= 32'(rxMark);
        IE:      PRDATA <= {30'b0, ie};
        IP:      PRDATA <= {30'b0, ip};
        default: PRDATA <= '0;
      endcase
    end
  end

  // Any enabled pending source raises the line
  assign SPIIntr = |(ip & ie);

endmodule

//--- hdl/spiController.sv
`timescale 1ns/10ps

module spiController import spiPkg::*; (
  input  logic    PCLK,
  input  logic    PRESETn,
  input  spiCfg   cfg,
  input  logic    txStart,
  input  logic    txEmpty,
  input  logic    sckRestart,
  output spiTicks ticks,
  output logic    busy,
  output logic    SPICLK
);

  frameState   state;
  logic [11:0] divCnt;
  logic        tick;
  // Low at the idle level, high between leading and trailing edge
  logic        sckLevel;
  logic [3:0]  bitCnt;
  logic        leading;
  logic        trailing;
  logic        lastBit;

  //////////////////////////////
  // Half-period divider
  //////////////////////////////
  // Tick every sckDiv+1 cycles
  assign tick = (divCnt == cfg.sckDiv);

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      divCnt <= '0;
    end else if (sckRestart || txStart || tick) begin
      // A new frame starts on a full half period
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 12'd1;
    end
  end

  // Serial clock edges, only while a frame is on the wire
  assign leading  = tick & (state == ACTIVE) & ~sckLevel;
  assign trailing = tick & (state == ACTIVE) & sckLevel;
  assign lastBit  = (bitCnt == cfg.frameLen - 4'd1);

  //////////////////////////////
  // Frame FSM
  //////////////////////////////
  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      state    <= IDLE;
      sckLevel <= 1'b0;
      bitCnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (txStart) begin
            state    <= ACTIVE;
            sckLevel <= 1'b0;
            bitCnt   <= '0;
          end
        end
        ACTIVE: begin
          if (tick) begin
            sckLevel <= ~sckLevel;
            // Bit count advances on the trailing edge
            if (sckLevel) begin
              if (lastBit) begin
                state  <= GAP;
                bitCnt <= '0;
              end else begin
                bitCnt <= bitCnt + 4'd1;
              end
            end
          end
        end
        GAP: begin
          // One idle tick, then straight on if more data waits
          if (tick) state <= txEmpty ? IDLE : ACTIVE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Phase 0 samples on leading, shifts on trailing
  // Phase 1 swaps them and skips the first shift, the MSB is already out
  assign ticks.sckTick    = tick;
  assign ticks.shiftEdge  = cfg.sckPha ? (leading & (bitCnt != 4'd0)) : trailing;
  assign ticks.sampleEdge = cfg.sckPha ? trailing : leading;
  assign ticks.endOfFrame = tick & (state == GAP);

  assign busy   = (state != IDLE);
  // Follows sckPol directly whenever no frame runs
  assign SPICLK = cfg.sckPol ^ sckLevel;

endmodule

//--- hdl/spiShifter.sv
`timescale 1ns/10ps

module spiShifter import spiPkg::*; (
  input  logic       PCLK,
  input  logic       PRESETn,
  input  spiCfg      cfg,
  input  spiTicks    ticks,
  input  logic       load,
  input  logic [7:0] txByte,
  input  logic       SPIIn,
  output logic       SPIOut,
  output logic [7:0] rxByte
);

  logic [7:0] txEndian;
  logic [7:0] txReg;
  logic [7:0] rxReg;
  logic [7:0] rxAligned;
  logic [3:0] alignShift;

  //////////////////////////////
  // Transmit side
  //////////////////////////////
  // Register always shifts MSB first, so LSB-first bytes are flipped on load
  assign txEndian = cfg.lsbFirst ? {<<{txByte}} : txByte;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      txReg <= '0;
    end else if (load) begin
      txReg <= txEndian;
    end else if (ticks.shiftEdge) begin
      txReg <= {txReg[6:0], 1'b0};
    end
  end

  assign SPIOut = txReg[7];

  //////////////////////////////
  // Receive side
  //////////////////////////////
  // Sampling is on the opposite edge from shifting
  always_ff @(posedge PCLK) begin
    if (ticks.sampleEdge) begin
      rxReg <= {rxReg[6:0], SPIIn};
    end
  end

  // Short frames land in the low bits, move them to the top
  assign alignShift = 4'd8 - cfg.frameLen;
  assign rxAligned  = rxReg << alignShift;
  // Undo the flip for LSB-first frames
  assign rxByte     = cfg.lsbFirst ? {<<{rxAligned}} : rxAligned;

endmodule

//--- hdl/spiApb.sv
`timescale 1ns/10ps

module spiApb import spiPkg::*; (
  input  logic        PCLK,
  input  logic        PRESETn,
  input  logic        PSEL,
  input  logic        PENABLE,
  input  logic        PWRITE,
  input  logic [7:0]  PADDR,
  input  logic [31:0] PWDATA,
  // Word-only registers, byte strobes are ignored
  input  logic [3:0]  PSTRB,
  output logic        PREADY,
  output logic [31:0] PRDATA,
  input  logic        SPIIn,
  output logic        SPIOut,
  output logic        SPICLK,
  output logic [3:0]  SPICS,
  output logic        SPIIntr
);

  spiCfg                   cfg;
  spiTicks                 ticks;
  startState               curState;
  startState               nextState;
  logic                    txPush, rxPop, sckRestart;
  logic [7:0]              txWrData, txHead, rxByte, rxRdData;
  logic [fifoDepthLog-1:0] txMark, rxMark;
  logic                    txFull, txEmpty, rxEmpty;
  logic                    txBelowMark, rxAboveMark;
  logic                    txStart, busy, load, loaded;

  // No wait states
  assign PREADY = 1'b1;

  spiRegs regs (.PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA,
    .cfg, .txPush, .txWrData, .rxPop, .txMark, .rxMark, .txFull, .rxEmpty, .rxRdData,
    .txBelowMark, .rxAboveMark, .sckRestart, .SPIIntr);

  spiController ctrl (.PCLK, .PRESETn, .cfg, .txStart, .txEmpty, .sckRestart,
    .ticks, .busy, .SPICLK);

  // First byte on txStart, later ones back to back at end of frame
  assign load = txStart | (ticks.endOfFrame & ~txEmpty);

  spiShifter shifter (.PCLK, .PRESETn, .cfg, .ticks, .load, .txByte(txHead), .SPIIn,
    .SPIOut, .rxByte);

  // Transmit FIFO pops as its head goes into the shift register
  spiFifo txFifo (.PCLK, .PRESETn, .push(txPush), .pop(load), .wrData(txWrData),
    .mark(txMark), .rdData(txHead), .full(txFull), .empty(txEmpty),
    .belowMark(txBelowMark), .aboveMark());

  // Completed frames drop silently when full
  spiFifo rxFifo (.PCLK, .PRESETn, .push(ticks.endOfFrame), .pop(rxPop), .wrData(rxByte),
    .mark(rxMark), .rdData(rxRdData), .full(), .empty(rxEmpty),
    .belowMark(), .aboveMark(rxAboveMark));

  //////////////////////////////
  // Transmit start FSM
  //////////////////////////////
  // Set on load, cleared once the first bit moves or the frame ends
  always_ff @(posedge PCLK) begin
    if (!PRESETn) loaded <= 1'b0;
    else if (load) loaded <= 1'b1;
    else if (ticks.shiftEdge || ticks.endOfFrame) loaded <= 1'b0;
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn) curState <= READY;
    else curState <= nextState;
  end

  always_comb begin
    nextState = curState;
    case (curState)
      READY: if (!txEmpty && !busy) nextState = START;
      START: nextState = WAIT;
      WAIT: if (!busy && !loaded) nextState = READY;
      default: nextState = READY;
    endcase
  end

  assign txStart = (curState == START);

  // Selected line inverts csDef while a frame runs, off mode holds csDef
  assign SPICS = (cfg.csOff || !busy) ? cfg.csDef : cfg.csDef ^ (4'b0001 << cfg.csId);

endmodule

//--- verif/spiApb_sva.sv
`timescale 1ns/10ps

module spiApbSva import spiPkg::*; (
  input logic       PCLK,
  input logic       PRESETn,
  input logic       PREADY,
  input logic       SPICLK,
  input logic       busy,
  input logic [3:0] SPICS,
  input spiCfg      cfg
);

  // Slave never inserts wait states
  apbReady: assert property (@(posedge PCLK) disable iff (!PRESETn) PREADY)
    else $error("PREADY went low");

  // Idle level, or exactly one select flipped from it
  csShape: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (SPICS == cfg.csDef) || $onehot(SPICS ^ cfg.csDef))
    else $error("SPICS %b is not a single select against csDef %b", SPICS, cfg.csDef);

  // Serial clock parked at its polarity between frames
  clkIdle: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !busy |-> (SPICLK == cfg.sckPol))
    else $error("SPICLK moved while the controller was idle");

endmodule

bind spiApb spiApbSva sva (.PCLK(PCLK), .PRESETn(PRESETn), .PREADY(PREADY),
  .SPICLK(SPICLK), .busy(busy), .SPICS(SPICS), .cfg(cfg));

//--- verif/spiTb.sv
`timescale 1ns/10ps

module spiTb import spiPkg::*; ();

  // Slowest test runs nine 8-bit frames at sckDiv 20 with 17 ticks of 21 cycles each
  localparam int slowTestCycles = 9 * 17 * 21;
  // The other tests are far shorter, so a few slow-test lengths cover the run
  localparam int watchdogCycles = 6 * slowTestCycles;
  localparam int transferLimit = slowTestCycles + 500;
  localparam int pollLimit = 32;

  logic        PCLK;
  logic        PRESETn;
  logic        PSEL;
  logic        PENABLE;
  logic        PWRITE;
  logic [7:0]  PADDR;
  logic [31:0] PWDATA;
  logic [3:0]  PSTRB;
  logic        PREADY;
  logic [31:0] PRDATA;
  logic        SPIIn;
  logic        SPIOut;
  logic        SPICLK;
  logic [3:0]  SPICS;
  logic        SPIIntr;
  int          errors;
  integer      seed;
  int          sckEdges = 0;

  spiApb uut (.PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PSTRB,
    .PREADY, .PRDATA, .SPIIn, .SPIOut, .SPICLK, .SPICS, .SPIIntr);

  // Serial loopback
  assign SPIIn = SPIOut;

  // Rising serial clock edges, one per bit at polarity 0
  always @(posedge SPICLK) sckEdges++;

  initial begin
    PCLK = 1'b0;
    forever #5 PCLK = ~PCLK;
  end

  //////////////////////////////
  // APB and helpers
  //////////////////////////////
  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
    @(negedge PCLK);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = 1'b1;
    PADDR = addr;
    PWDATA = data;
    @(negedge PCLK);
    PENABLE = 1'b1;
    @(negedge PCLK);
    PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  // PRDATA is stable for the whole access phase
  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
    @(negedge PCLK);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = addr;
    @(negedge PCLK);
    PENABLE = 1'b1;
    data = PRDATA;
    @(negedge PCLK);
    PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic checkEq(input string name, input logic [31:0] want, input logic [31:0] got);
    assert (got === want) else begin
      $display("FAIL %s: expected %h, actual %h", name, want, got);
      errors++;
    end
  endtask

  // Waits for the chip select to drop and then return to its idle level
  task automatic waitTransfer(input string name);
    int n;
    n = 0;
    while (SPICS == 4'hF && n < transferLimit) begin
      @(negedge PCLK);
      n++;
    end
    while (SPICS != 4'hF && n < transferLimit) begin
      @(negedge PCLK);
      n++;
    end
    assert (n < transferLimit) else begin
      $display("%s: transfer did not finish within %0d cycles", name, transferLimit);
      errors++;
    end
  endtask

  task automatic waitIntr(input string name);
    int n;
    n = 0;
    while (!SPIIntr && n < transferLimit) begin
      @(negedge PCLK);
      n++;
    end
    assert (SPIIntr) else begin
      $display("%s: interrupt line never rose", name);
      errors++;
    end
  endtask

  // Polls RXDATA until a byte is there; bit 31 stays set if none came
  task automatic readRx(output logic [31:0] data);
    int n;
    n = 0;
    apbRead(RXDATA, data);
    while (data[31] && n < pollLimit) begin
      apbRead(RXDATA, data);
      n++;
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic testReset();
    logic [7:0]  addrs [11];
    logic [31:0] want [11];
    logic [31:0] rd;
    addrs = '{SCKDIV, SCKMODE, CSID, CSDEF, CSMODE, FMT, TXDATA, TXMARK, RXMARK, IE, IP};
    // Div 3, CS all high, 8-bit MSB-first frames
    want = '{32'h3, 32'h0, 32'h0, 32'hF, 32'h0, 32'h0008_0000, 32'h0, 32'h0, 32'h0,
      32'h0, 32'h0};
    for (int i = 0; i < 11; i++) begin
      apbRead(addrs[i], rd);
      checkEq($sformatf("reset 0x%02h", addrs[i]), want[i], rd);
    end
    // Receive FIFO starts empty and its data byte is undefined
    apbRead(RXDATA, rd);
    checkEq("reset RXDATA empty", 32'h1, {31'h0, rd[31]});
    checkEq("reset SPICS", 32'hF, {28'h0, SPICS});
    checkEq("reset SPIIntr", 32'h0, {31'h0, SPIIntr});
    // Serial clock parks at polarity 0 and the data line is low
    checkEq("reset SPICLK", 32'h0, {31'h0, SPICLK});
    checkEq("reset SPIOut", 32'h0, {31'h0, SPIOut});
  endtask

  task automatic testRegs();
    logic [7:0]  addrs [7];
    logic [31:0] wr [7];
    logic [31:0] want [7];
    logic [31:0] rd;
    addrs = '{SCKDIV, CSID, CSDEF, FMT, TXMARK, RXMARK, IE};
    wr = '{32'hFFFF_F123, 32'hFFFF_FFFE, 32'hFFFF_FFF5, 32'hFFFF_FFFF, 32'hFFFF_FFFD,
      32'hFFFF_FFFA, 32'hFFFF_FFFE};
    // Field widths 12, 2, 4, len+endian, 3, 3, 2
    want = '{32'h123, 32'h2, 32'h5, 32'h000F_0004, 32'h5, 32'h2, 32'h2};
    for (int i = 0; i < 7; i++) begin
      apbWrite(addrs[i], wr[i]);
      apbRead(addrs[i], rd);
      checkEq($sformatf("regs 0x%02h", addrs[i]), want[i], rd);
    end
    apbRead(8'h08, rd);
    checkEq("unmapped 0x08", 32'h0, rd);
    apbRead(8'h2C, rd);
    checkEq("unmapped 0x2C", 32'h0, rd);
    apbRead(8'h7C, rd);
    checkEq("unmapped 0x7C", 32'h0, rd);
    // Back to the reset configuration
    wr = '{32'h3, 32'h0, 32'hF, 32'h0008_0000, 32'h0, 32'h0, 32'h0};
    for (int i = 0; i < 7; i++) apbWrite(addrs[i], wr[i]);
  endtask

  task automatic testLoopback();
    logic [7:0]  sent [4];
    logic [31:0] rd;
    apbWrite(CSID, 32'h1);
    for (int i = 0; i < 4; i++) begin
      sent[i] = 8'($random(seed));
      apbWrite(TXDATA, {24'h0, sent[i]});
    end
    // First frame is still on the wire with select 1 pulled low
    checkEq("loopback SPICS", 32'hD, {28'h0, SPICS});
    waitTransfer("loopback");
    for (int i = 0; i < 4; i++) begin
      readRx(rd);
      checkEq($sformatf("loopback byte %0d", i), {24'h0, sent[i]}, rd);
    end
    apbWrite(CSID, 32'h0);
  endtask

  task automatic testFrameLen();
    logic [7:0]  b;
    logic [31:0] rd;
    int          edgesBefore;
    // 5-bit MSB-first keeps the top five bits
    apbWrite(FMT, 32'h0005_0000);
    b = 8'($random(seed));
    edgesBefore = sckEdges;
    apbWrite(TXDATA, {24'h0, b});
    waitTransfer("frame MSB-first");
    checkEq("frame MSB-first clocks", 32'd5, sckEdges - edgesBefore);
    readRx(rd);
    checkEq("frame MSB-first", {24'h0, b & 8'hF8}, rd);
    // 5-bit LSB-first keeps the bottom five
    apbWrite(FMT, 32'h0005_0004);
    b = 8'($random(seed));
    apbWrite(TXDATA, {24'h0, b});
    waitTransfer("frame LSB-first");
    readRx(rd);
    checkEq("frame LSB-first", {24'h0, b & 8'h1F}, rd);
    apbWrite(FMT, 32'h0008_0000);
  endtask

  task automatic testFifoFull();
    logic [7:0]  sent [10];
    logic [31:0] rd;
    apbWrite(SCKDIV, 32'd20);
    // Byte 0 goes to the shifter, 1 to 8 fill the FIFO, byte 9 is dropped
    for (int i = 0; i < 10; i++) begin
      sent[i] = 8'($random(seed));
      apbWrite(TXDATA, {24'h0, sent[i]});
    end
    apbRead(TXDATA, rd);
    checkEq("fifo full flag", 32'h8000_0000, rd);
    waitTransfer("fifo full");
    // Nine frames ran and the last one found the receive FIFO full
    for (int i = 0; i < 8; i++) begin
      readRx(rd);
      checkEq($sformatf("fifo full byte %0d", i), {24'h0, sent[i]}, rd);
    end
    apbRead(RXDATA, rd);
    checkEq("fifo full drained", 32'h1, {31'h0, rd[31]});
    apbWrite(SCKDIV, 32'd3);
  endtask

  task automatic testInterrupts();
    logic [7:0]  sent [3];
    logic [31:0] rd;
    // Transmit watermark fires once fewer than one byte waits
    apbWrite(TXMARK, 32'h1);
    for (int i = 0; i < 3; i++) begin
      sent[i] = 8'($random(seed));
      apbWrite(TXDATA, {24'h0, sent[i]});
    end
    apbWrite(IE, 32'h1);
    checkEq("tx irq quiet", 32'h0, {31'h0, SPIIntr});
    waitIntr("tx irq");
    waitTransfer("tx irq");
    for (int i = 0; i < 3; i++) begin
      readRx(rd);
      checkEq($sformatf("tx irq byte %0d", i), {24'h0, sent[i]}, rd);
    end
    apbWrite(IE, 32'h0);
    apbWrite(TXMARK, 32'h0);
    // Receive watermark fires while anything waits
    apbWrite(RXMARK, 32'h0);
    apbWrite(IE, 32'h2);
    checkEq("rx irq quiet", 32'h0, {31'h0, SPIIntr});
    sent[0] = 8'($random(seed));
    apbWrite(TXDATA, {24'h0, sent[0]});
    waitIntr("rx irq");
    readRx(rd);
    checkEq("rx irq byte", {24'h0, sent[0]}, rd);
    apbRead(RXDATA, rd);
    checkEq("rx irq drained", 32'h1, {31'h0, rd[31]});
    checkEq("rx irq cleared", 32'h0, {31'h0, SPIIntr});
    apbWrite(IE, 32'h0);
  endtask

  //////////////////////////////
  // Sequence and watchdog
  //////////////////////////////
  initial begin
    PRESETn = 1'b0;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = 8'h0;
    PWDATA = 32'h0;
    PSTRB = 4'hF;
    errors = 0;
    seed = 16968;
    repeat (2) @(negedge PCLK);
    PRESETn = 1'b1;
    testReset();
    testRegs();
    testLoopback();
    testFrameLen();
    testFifoFull();
    testInterrupts();
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdogCycles) @(posedge PCLK);
    $display("Watchdog expired after %0d cycles with %0d errors", watchdogCycles, errors);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- tb.f
hdl/spiPkg.sv
hdl/spiFifo.sv
hdl/spiRegs.sv
hdl/spiController.sv
hdl/spiShifter.sv
hdl/spiApb.sv
verif/spiApb_sva.sv
verif/spiTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module spiTb -o spiTbSim
./obj_dir/spiTbSim | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
